// File: design/issue_defs.svh
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Instruction and data word width
`define INSTR_W 16

// Queue entries, also the credit pool size after reset
`define QUEUE_DEPTH 4

// Past issue cycles checked for hazards
// one per later pipeline stage (ID, EX, MEM, WB)
`define HIST_DEPTH 4

// Field widths inside an instruction word
`define OPCODE_W 5
`define REG_IDX_W 3
`define MEM_IMM_W 5

`endif

// File: design/issuePkg.sv
`include "issue_defs.svh"

package issuePkg;

    typedef logic [`INSTR_W-1:0]                 instrT;
    typedef logic [`REG_IDX_W-1:0]               regIdxT;
    typedef logic [`INSTR_W-1:0]                 addrT;
    typedef logic [$clog2(`QUEUE_DEPTH + 1)-1:0] creditT;
    typedef logic [`OPCODE_W-1:0]                opcodeT;

    // Full opcodes
    localparam opcodeT opHalt   = 5'b00000;
    localparam opcodeT opNop    = 5'b00001;
    localparam opcodeT opStore  = 5'b10000;
    localparam opcodeT opLoad   = 5'b10001;
    localparam opcodeT opAluReg = 5'b11011;

    // Opcode classes, top three bits
    localparam logic [2:0] clsJump   = 3'b001;
    localparam logic [2:0] clsAluImm = 3'b010;
    localparam logic [2:0] clsBranch = 3'b011;

    function automatic opcodeT opcodeOf(instrT instr);
        return instr[15:11];
    endfunction

    function automatic logic isHalt(instrT instr);
        return opcodeOf(instr) == opHalt;
    endfunction

    function automatic logic isNop(instrT instr);
        return opcodeOf(instr) == opNop;
    endfunction

    function automatic regIdxT srcA(instrT instr);
        return instr[10:8];
    endfunction

    function automatic regIdxT srcB(instrT instr);
        return instr[7:5];
    endfunction

    function automatic logic writesReg(instrT instr);
        return (opcodeOf(instr) == opAluReg) || (opcodeOf(instr) == opLoad) ||
               (instr[15:13] == clsAluImm);
    endfunction

    // Register ALU writes bits 4-2, immediate forms write bits 7-5
    function automatic regIdxT destReg(instrT instr);
        return (opcodeOf(instr) == opAluReg) ? instr[4:2] : instr[7:5];
    endfunction

    function automatic logic isMemOp(instrT instr);
        return (opcodeOf(instr) == opLoad) || (opcodeOf(instr) == opStore);
    endfunction

    function automatic addrT memImm(instrT instr);
        return {{(`INSTR_W - `MEM_IMM_W){instr[4]}}, instr[4:0]};
    endfunction

    function automatic logic isCtrl(instrT instr);
        return (instr[15:13] == clsJump) || (instr[15:13] == clsBranch);
    endfunction

endpackage

// File: design/fetchUnit.sv
`include "issue_defs.svh"

module fetchUnit
    import issuePkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  logic  run,
    output addrT  imemAddr,
    input  instrT imemData,
    output logic  pushValid,
    output instrT pushInstr,
    input  logic  creditReturn,
    output logic  halted
);

    addrT   pc;
    creditT creditCnt;
    logic   fetchOk;
    logic   fetchGo;
    logic   haltSeen;

    assign imemAddr = pc;

    // A read slot exists this cycle
    assign fetchOk  = run && !halted && (creditCnt != '0);
    assign haltSeen = fetchOk && isHalt(imemData);
    // Halt word itself is never pushed
    assign fetchGo  = fetchOk && !isHalt(imemData);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            halted    <= 1'b0;
            pushValid <= 1'b0;
            creditCnt <= creditT'(`QUEUE_DEPTH);
        end else begin
            pushValid <= fetchGo;
            if (fetchGo) begin
                pc <= pc + addrT'(1);
            end
            if (haltSeen) begin
                halted <= 1'b1;
            end
            // Spend on fetch, refund on each queue pop
            creditCnt <= creditCnt - creditT'(fetchGo) + creditT'(creditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (fetchGo) begin
            pushInstr <= imemData;
        end
    end

    creditBound: assert property (
        @(posedge clk) disable iff (!arstN)
        creditCnt <= creditT'(`QUEUE_DEPTH)
    ) else $error("credit count above queue depth");

endmodule

// File: design/instrQueue.sv
`include "issue_defs.svh"

module instrQueue
    import issuePkg::*;
(
    input  logic  clk,
    input  logic  arstN,
    input  logic  pushValid,
    input  instrT pushInstr,
    output logic  headValid,
    output instrT headInstr,
    input  logic  pop,
    output logic  creditReturn
);

    localparam int PtrW = $clog2(`QUEUE_DEPTH);

    instrT            mem [`QUEUE_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    creditT           count;
    logic             doPop;

    // Wraps at the last entry, depth need not be a power of two
    function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] p);
        return (p == PtrW'(`QUEUE_DEPTH - 1)) ? '0 : p + PtrW'(1);
    endfunction

    assign headValid = (count != '0);
    assign headInstr = mem[rdPtr];
    assign doPop     = pop && headValid;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count        <= count + creditT'(pushValid) - creditT'(doPop);
            // One credit back per entry leaving
            creditReturn <= doPop;
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            mem[wrPtr] <= pushInstr;
        end
    end

    // Producer must respect its credits
    noOverflow: assert property (
        @(posedge clk) disable iff (!arstN)
        pushValid |-> (count != creditT'(`QUEUE_DEPTH)) || doPop
    ) else $error("push into full instruction queue");

    noUnderflow: assert property (
        @(posedge clk) disable iff (!arstN)
        pop |-> headValid
    ) else $error("pop from empty instruction queue");

endmodule

// File: design/hazardIssue.sv
`include "issue_defs.svh"

module hazardIssue
    import issuePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   headValid,
    input  instrT  headInstr,
    output logic   pop,
    output regIdxT rsAddr,
    input  instrT  rsData,
    output logic   issueValid,
    output instrT  issueInstr,
    output logic   bubble
);

    // Issue history with entry 0 as the previous cycle
    logic   histValid  [`HIST_DEPTH];
    logic   histWrites [`HIST_DEPTH];
    regIdxT histDest   [`HIST_DEPTH];
    logic   histMem    [`HIST_DEPTH];
    addrT   histAddr   [`HIST_DEPTH];

    logic   ctrlPrev;
    regIdxT headSrcA;
    regIdxT headSrcB;
    addrT   headAddr;
    logic   regHaz;
    logic   memHaz;
    logic   stall;

    assign headSrcA = srcA(headInstr);
    assign headSrcB = srcB(headInstr);

    // Base register for the memory address
    assign rsAddr   = headSrcA;
    assign headAddr = rsData + memImm(headInstr);

    // RAW and memory conflicts against the last few issue cycles
    always_comb begin
        regHaz = 1'b0;
        memHaz = 1'b0;
        for (int i = 0; i < `HIST_DEPTH; i++) begin
            if (histValid[i] && histWrites[i] &&
                ((histDest[i] == headSrcA) || (histDest[i] == headSrcB))) begin
                regHaz = 1'b1;
            end
            if (histValid[i] && histMem[i] && (histAddr[i] == headAddr)) begin
                memHaz = 1'b1;
            end
        end
        // A nop reads nothing
        if (isNop(headInstr)) begin
            regHaz = 1'b0;
        end
        if (!isMemOp(headInstr)) begin
            memHaz = 1'b0;
        end
    end

    // Jump or branch issued last cycle costs one slot
    assign stall = regHaz || memHaz || ctrlPrev;
    assign pop   = headValid && !stall;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `HIST_DEPTH; i++) begin
                histValid[i] <= 1'b0;
            end
            ctrlPrev   <= 1'b0;
            issueValid <= 1'b0;
            bubble     <= 1'b0;
        end else begin
            // Empty cycles and bubbles shift in as invalid
            histValid[0] <= pop;
            for (int i = 1; i < `HIST_DEPTH; i++) begin
                histValid[i] <= histValid[i-1];
            end
            ctrlPrev   <= pop && isCtrl(headInstr);
            issueValid <= pop;
            bubble     <= headValid && stall;
        end
    end

    // Payload is read only under its valid bit
    always_ff @(posedge clk) begin
        histWrites[0] <= writesReg(headInstr);
        histDest[0]   <= destReg(headInstr);
        histMem[0]    <= isMemOp(headInstr);
        histAddr[0]   <= headAddr;
        for (int i = 1; i < `HIST_DEPTH; i++) begin
            histWrites[i] <= histWrites[i-1];
            histDest[i]   <= histDest[i-1];
            histMem[i]    <= histMem[i-1];
            histAddr[i]   <= histAddr[i-1];
        end
        if (pop) begin
            issueInstr <= headInstr;
        end
    end

    issueOrBubble: assert property (
        @(posedge clk) disable iff (!arstN)
        !(issueValid && bubble)
    ) else $error("issue and bubble in the same cycle");

endmodule

// File: design/issueTop.sv
module issueTop
    import issuePkg::*;
(
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    output addrT   imemAddr,
    input  instrT  imemData,
    output regIdxT rsAddr,
    input  instrT  rsData,
    output logic   issueValid,
    output instrT  issueInstr,
    output logic   bubble,
    output logic   halted
);

    // Fetch to queue, credit handshake
    logic  pushValid;
    instrT pushInstr;
    logic  creditReturn;

    // Queue to issue stage
    logic  headValid;
    instrT headInstr;
    logic  pop;

    fetchUnit u_fetch (
        .clk          (clk),
        .arstN        (arstN),
        .run          (run),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .pushValid    (pushValid),
        .pushInstr    (pushInstr),
        .creditReturn (creditReturn),
        .halted       (halted)
    );

    instrQueue u_queue (
        .clk          (clk),
        .arstN        (arstN),
        .pushValid    (pushValid),
        .pushInstr    (pushInstr),
        .headValid    (headValid),
        .headInstr    (headInstr),
        .pop          (pop),
        .creditReturn (creditReturn)
    );

    hazardIssue u_issue (
        .clk        (clk),
        .arstN      (arstN),
        .headValid  (headValid),
        .headInstr  (headInstr),
        .pop        (pop),
        .rsAddr     (rsAddr),
        .rsData     (rsData),
        .issueValid (issueValid),
        .issueInstr (issueInstr),
        .bubble     (bubble)
    );

endmodule

// File: tb/clockGen.sv
module clockGen (
    output logic clk,
    output logic arstN
);

    localparam int HalfPeriod  = 4;
    localparam int ResetCycles = 3;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// File: tb/issueTb.sv
`include "issue_defs.svh"

module issueTb
    import issuePkg::*;
();

    localparam int MemWords  = 64;
    localparam int WaitLimit = 2000;
    localparam int DrainIdle = 3;

    localparam logic [1:0] KindIdle   = 2'd0;
    localparam logic [1:0] KindIssue  = 2'd1;
    localparam logic [1:0] KindBubble = 2'd2;

    localparam instrT HaltWord   = 16'h0000;
    localparam instrT NopWord    = {5'b00001, 11'h000};
    localparam instrT JumpWord   = {3'b001, 13'h0000};
    localparam instrT BranchWord = {3'b011, 13'h0000};

    logic   clk;
    logic   genRstN;
    logic   testRstN;
    logic   arstN;
    logic   run;
    addrT   imemAddr;
    instrT  imemData;
    regIdxT rsAddr;
    instrT  rsData;
    logic   issueValid;
    instrT  issueInstr;
    logic   bubble;
    logic   halted;

    instrT       imem [MemWords];
    instrT       prog [$];
    logic [1:0]  traceKind [$];
    instrT       traceInstr [$];
    int          valueErrs;
    int          ruleErrs;
    logic [31:0] lcgState;

    // Reference history for the hazard model
    logic   mValid  [`HIST_DEPTH];
    logic   mWrites [`HIST_DEPTH];
    regIdxT mDest   [`HIST_DEPTH];
    logic   mMem    [`HIST_DEPTH];
    addrT   mAddr   [`HIST_DEPTH];
    logic   modelCtrl;

    clockGen u_clk (
        .clk   (clk),
        .arstN (genRstN)
    );

    assign arstN    = genRstN && testRstN;
    assign imemData = imem[imemAddr[5:0]];
    // Register r holds 16 * r
    assign rsData   = instrT'(rsAddr) << 4;

    issueTop u_dut (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .rsAddr     (rsAddr),
        .rsData     (rsData),
        .issueValid (issueValid),
        .issueInstr (issueInstr),
        .bubble     (bubble),
        .halted     (halted)
    );

    function automatic instrT aluRegWord(regIdxT rd, regIdxT ra, regIdxT rb);
        return {5'b11011, ra, rb, rd, 2'b00};
    endfunction

    function automatic instrT aluImmWord(regIdxT rd, regIdxT ra, logic [4:0] imm);
        return {3'b010, 2'b00, ra, rd, imm};
    endfunction

    function automatic instrT loadWord(regIdxT rd, regIdxT base, logic [4:0] imm);
        return {5'b10001, base, rd, imm};
    endfunction

    // Unused memory holds nops tagged with their own address
    function automatic instrT fillWord(int a);
        return {5'b00001, 5'b00000, a[5:0]};
    endfunction

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic writesAny(instrT w);
        return (w[15:11] == 5'b11011) || (w[15:11] == 5'b10001) || (w[15:13] == 3'b010);
    endfunction

    function automatic regIdxT destOf(instrT w);
        if (w[15:11] == 5'b11011) begin
            return w[4:2];
        end
        return w[7:5];
    endfunction

    function automatic logic memAccess(instrT w);
        return (w[15:11] == 5'b10000) || (w[15:11] == 5'b10001);
    endfunction

    // Base register value plus sign-extended offset
    function automatic addrT memAddress(instrT w);
        return (addrT'(w[10:8]) << 4) + {{11{w[4]}}, w[4:0]};
    endfunction

    function automatic logic transfersControl(instrT w);
        return (w[15:13] == 3'b001) || (w[15:13] == 3'b011);
    endfunction

    function automatic logic conflicts(instrT w);
        logic hit;
        hit = modelCtrl;
        for (int i = 0; i < `HIST_DEPTH; i++) begin
            if (mValid[i] && mWrites[i] && (w[15:11] != 5'b00001) &&
                ((mDest[i] == w[10:8]) || (mDest[i] == w[7:5]))) begin
                hit = 1'b1;
            end
            if (mValid[i] && mMem[i] && memAccess(w) && (mAddr[i] == memAddress(w))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic shiftHistory(input logic v, input instrT w);
        for (int i = `HIST_DEPTH - 1; i > 0; i--) begin
            mValid[i]  = mValid[i-1];
            mWrites[i] = mWrites[i-1];
            mDest[i]   = mDest[i-1];
            mMem[i]    = mMem[i-1];
            mAddr[i]   = mAddr[i-1];
        end
        mValid[0]  = v;
        mWrites[0] = writesAny(w);
        mDest[0]   = destOf(w);
        mMem[0]    = memAccess(w);
        mAddr[0]   = memAddress(w);
        modelCtrl  = v && transfersControl(w);
    endtask

    task automatic checkInstr(input string what, input instrT got, input instrT exp);
        if (got !== exp) begin
            $display("error at %0t: %s issued %h, expected %h", $time, what, got, exp);
            valueErrs++;
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t: %s count %0d, expected %0d", $time, what, got, exp);
            valueErrs++;
        end
    endtask

    function automatic int bubbleCount();
        int n;
        n = 0;
        for (int k = 0; k < traceKind.size(); k++) begin
            if (traceKind[k] == KindBubble) begin
                n++;
            end
        end
        return n;
    endfunction

    // Reset, load prog, run and record one decision per cycle until drained
    task automatic runProgram();
        int idle;
        int cycles;
        @(negedge clk);
        run      = 1'b0;
        testRstN = 1'b0;
        for (int a = 0; a < MemWords; a++) begin
            imem[a] = fillWord(a);
        end
        for (int a = 0; a < prog.size(); a++) begin
            imem[a] = prog[a];
        end
        traceKind.delete();
        traceInstr.delete();
        @(negedge clk);
        testRstN = 1'b1;
        @(negedge clk);
        run    = 1'b1;
        idle   = 0;
        cycles = 0;
        while (!(halted && (idle >= DrainIdle)) && (cycles < WaitLimit)) begin
            @(negedge clk);
            cycles++;
            if (issueValid) begin
                traceKind.push_back(KindIssue);
                idle = 0;
            end else if (bubble) begin
                traceKind.push_back(KindBubble);
                idle = 0;
            end else begin
                traceKind.push_back(KindIdle);
                // Only empty cycles after the halt mean drained
                idle = halted ? idle + 1 : 0;
            end
            traceInstr.push_back(issueInstr);
        end
        if (cycles >= WaitLimit) begin
            $display("timeout: program did not halt and drain within %0d cycles", WaitLimit);
            ruleErrs++;
        end
        run = 1'b0;
    endtask

    // Replay the trace against the hazard rules
    task automatic checkTrace(input string name);
        int next;
        int total;
        next  = 0;
        total = prog.size() - 1;
        for (int i = 0; i < `HIST_DEPTH; i++) begin
            mValid[i] = 1'b0;
        end
        modelCtrl = 1'b0;
        for (int k = 0; k < traceKind.size(); k++) begin
            if (traceKind[k] == KindIdle) begin
                shiftHistory(1'b0, NopWord);
            end else if (next >= total) begin
                $display("%s: decision in cycle %0d with no instruction left", name, k);
                ruleErrs++;
                shiftHistory(1'b0, NopWord);
            end else if (traceKind[k] == KindIssue) begin
                checkInstr(name, traceInstr[k], prog[next]);
                if (conflicts(prog[next])) begin
                    $display("%s: %h issued in cycle %0d despite a hazard", name, prog[next], k);
                    ruleErrs++;
                end
                shiftHistory(1'b1, prog[next]);
                next++;
            end else begin
                if (!conflicts(prog[next])) begin
                    $display("%s: bubble in cycle %0d before %h has no cause", name, k, prog[next]);
                    ruleErrs++;
                end
                shiftHistory(1'b0, NopWord);
            end
        end
        checkCount({name, " issued"}, next, total);
    endtask

    task automatic testIndependent();
        prog = '{aluRegWord(4, 0, 1), aluRegWord(5, 2, 3), aluRegWord(6, 1, 2),
                 aluRegWord(7, 3, 0), aluRegWord(4, 0, 2), HaltWord};
        runProgram();
        checkTrace("independent");
        checkCount("independent bubble", bubbleCount(), 0);
    endtask

    task automatic testRawDistance();
        prog = '{aluRegWord(1, 0, 0), aluRegWord(2, 1, 0), HaltWord};
        runProgram();
        checkTrace("raw adjacent");
        checkCount("raw adjacent bubble", bubbleCount(), 4);
        // One independent instruction in between
        prog = '{aluRegWord(1, 0, 0), aluRegWord(5, 2, 3), aluRegWord(2, 1, 0), HaltWord};
        runProgram();
        checkTrace("raw gap");
        checkCount("raw gap bubble", bubbleCount(), 3);
    endtask

    task automatic testMemConflict();
        // 2*16 - 16 and 1*16 + 0 both reach address 16
        prog = '{loadWord(3, 2, 5'b10000), loadWord(4, 1, 5'b00000), HaltWord};
        runProgram();
        checkTrace("load same address");
        checkCount("load same address bubble", bubbleCount(), 4);
        prog = '{loadWord(4, 1, 5'b00000), loadWord(5, 1, 5'b00001), HaltWord};
        runProgram();
        checkTrace("load other address");
        checkCount("load other address bubble", bubbleCount(), 0);
    endtask

    task automatic testControl();
        prog = '{aluRegWord(4, 0, 1), JumpWord, aluRegWord(5, 2, 3), BranchWord,
                 aluRegWord(6, 0, 1), HaltWord};
        runProgram();
        checkTrace("control");
        checkCount("control bubble", bubbleCount(), 2);
    endtask

    task automatic testRandom();
        logic [31:0] r;
        prog.delete();
        for (int n = 0; n < 40; n++) begin
            r = nextRandom();
            case (r[31:30])
                2'd0:    prog.push_back(NopWord);
                2'd3:    prog.push_back(aluImmWord(r[23:21], r[29:27], r[20:16]));
                default: prog.push_back(aluRegWord(r[23:21], r[29:27], r[26:24]));
            endcase
        end
        prog.push_back(HaltWord);
        runProgram();
        checkTrace("random");
    endtask

    initial begin
        int waitCycles;
        run       = 1'b0;
        testRstN  = 1'b1;
        valueErrs = 0;
        ruleErrs  = 0;
        lcgState  = 32'h977a_bb7c;
        for (int a = 0; a < MemWords; a++) begin
            imem[a] = fillWord(a);
        end
        waitCycles = 0;
        while (!genRstN && (waitCycles < 20)) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!genRstN) begin
            $display("reset was never released by the clock generator");
            ruleErrs++;
        end
        testIndependent();
        testRawDistance();
        testMemConflict();
        testControl();
        testRandom();
        $display("Errors: %0d wrong values, %0d rule or timeout failures", valueErrs, ruleErrs);
        if ((valueErrs == 0) && (ruleErrs == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+design
design/issuePkg.sv
design/fetchUnit.sv
design/instrQueue.sv
design/hazardIssue.sv
design/issueTop.sv
tb/clockGen.sv
tb/issueTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f project.f --top-module issueTb -o issueSim \
    && ./obj_dir/issueSim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log \
    && { echo "testbench reported failure"; exit 1; } \
    || grep -q "Simulation PASSED" sim.log \
    || { echo "no result line in log"; exit 1; }
